// File: verilog/rv_pkg.sv
// shared widths, opcodes and enums of the rv32i pipeline, pulled in by every RTL module
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMEM_WORDS = 64;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_WORDS = 16;                  // indexed by address bits [5:2]
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // rv32i major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;  // addi x0,x0,0

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B       // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_NONE,        // bubble
        CLS_ALU,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JAL,
        CLS_HALT
    } instr_class_e;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

endpackage

// File: verilog/if_stage.sv
// fetch stage: pc, instruction memory written during reset, and the IF/ID register
`timescale 1ns/1ps
module if_stage import rv_pkg::*; (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               imem_we_i,
    input  logic [IMEM_AW-1:0] imem_addr_i,
    input  logic [XLEN-1:0]    imem_wdata_i,
    input  logic               stall_i,
    input  logic               freeze_i,
    input  logic               flush_i,
    input  logic [XLEN-1:0]    flush_target_i,
    input  logic               fetch_stop_i,
    output logic               id_valid_o,
    output logic [XLEN-1:0]    id_pc_o,
    output logic [31:0]        id_instr_o
);
    logic [31:0]     imem [IMEM_WORDS];
    logic [XLEN-1:0] pc_q;
    logic            stopped_q;    // ebreak seen, issue only bubbles

    always_ff @(posedge clk) begin
        if (rst_i && imem_we_i) begin
            imem[imem_addr_i] <= imem_wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q       <= RESET_PC;
            stopped_q  <= 1'b0;
            id_valid_o <= 1'b0;
            id_instr_o <= NOP_INSTR;
        end else if (!freeze_i && flush_i) begin
            pc_q       <= flush_target_i;   // redirect, younger fetch dropped
            stopped_q  <= 1'b0;
            id_valid_o <= 1'b0;
            id_instr_o <= NOP_INSTR;
        end else if (!freeze_i && !stall_i) begin
            if (fetch_stop_i || stopped_q) begin
                stopped_q  <= 1'b1;
                id_valid_o <= 1'b0;
                id_instr_o <= NOP_INSTR;
            end else begin
                pc_q       <= pc_q + 32'd4;
                id_valid_o <= 1'b1;
                id_pc_o    <= pc_q;
                id_instr_o <= imem[pc_q[IMEM_AW+1:2]];
            end
        end
    end

endmodule

// File: verilog/id_stage.sv
// decode stage: instruction decode, immediates, operand forwarding and the ID/EX register
`timescale 1ns/1ps
module id_stage import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  id_valid_i,
    input  logic [XLEN-1:0]       id_pc_i,
    input  logic [31:0]           id_instr_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  fwd_sel_e              fwd_a_sel_i,
    input  fwd_sel_e              fwd_b_sel_i,
    input  logic [XLEN-1:0]       mem_result_i,   // value headed for MEM
    input  logic [XLEN-1:0]       wb_data_i,      // value headed for WB
    input  logic                  stall_i,
    input  logic                  freeze_i,
    input  logic                  flush_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    output logic                  fetch_stop_o,
    output logic                  ex_valid_o,
    output instr_class_e          ex_class_o,
    output alu_op_e               ex_alu_op_o,
    output logic [XLEN-1:0]       ex_src1_o,
    output logic [XLEN-1:0]       ex_src2_o,
    output logic [REG_ADDR_W-1:0] ex_rd_o,
    output logic [XLEN-1:0]       ex_store_data_o,
    output logic [XLEN-1:0]       ex_pc_o,
    output logic [XLEN-1:0]       ex_imm_o,
    output logic [2:0]            ex_funct3_o
);
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    instr_class_e          cls;
    alu_op_e               alu_op;
    alu_op_e               reg_op;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       op_a, op_b;
    logic                  use_rs1, use_rs2, use_imm, writes_rd;

    assign opcode = id_instr_i[6:0];
    assign funct3 = id_instr_i[14:12];

    // shared funct3 map of register and immediate alu ops
    always_comb begin
        case (funct3)
            3'b111:  reg_op = ALU_AND;
            3'b110:  reg_op = ALU_OR;
            3'b100:  reg_op = ALU_XOR;
            3'b010:  reg_op = ALU_SLT;
            default: reg_op = ALU_ADD;
        endcase
    end

    always_comb begin
        cls       = CLS_ALU;        // unknown opcodes retire as a nop
        alu_op    = ALU_ADD;
        imm       = '0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        use_imm   = 1'b1;
        writes_rd = 1'b0;
        case (opcode)
            OPC_OP: begin
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                use_imm   = 1'b0;
                writes_rd = 1'b1;
                alu_op    = (funct3 == 3'b000 && id_instr_i[30]) ? ALU_SUB : reg_op;
            end
            OPC_OP_IMM: begin
                use_rs1   = 1'b1;
                writes_rd = 1'b1;
                alu_op    = reg_op;
                imm       = {{20{id_instr_i[31]}}, id_instr_i[31:20]};
            end
            OPC_LUI: begin
                writes_rd = 1'b1;
                alu_op    = ALU_PASS_B;
                imm       = {id_instr_i[31:12], 12'b0};
            end
            OPC_LOAD: begin
                cls       = CLS_LOAD;
                use_rs1   = 1'b1;
                writes_rd = 1'b1;
                imm       = {{20{id_instr_i[31]}}, id_instr_i[31:20]};
            end
            OPC_STORE: begin
                cls     = CLS_STORE;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;             // store data
                imm     = {{20{id_instr_i[31]}}, id_instr_i[31:25], id_instr_i[11:7]};
            end
            OPC_BRANCH: begin
                cls     = CLS_BRANCH;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_imm = 1'b0;
                imm     = {{19{id_instr_i[31]}}, id_instr_i[31], id_instr_i[7],
                           id_instr_i[30:25], id_instr_i[11:8], 1'b0};
            end
            OPC_JAL: begin
                cls       = CLS_JAL;
                writes_rd = 1'b1;
                imm       = {{11{id_instr_i[31]}}, id_instr_i[31], id_instr_i[19:12],
                             id_instr_i[20], id_instr_i[30:21], 1'b0};
            end
            OPC_SYSTEM: cls = CLS_HALT;
            default: ;
        endcase
    end

    // non-readers present x0 so no false hazard is seen
    assign rs1_addr_o   = (id_valid_i && use_rs1) ? id_instr_i[19:15] : '0;
    assign rs2_addr_o   = (id_valid_i && use_rs2) ? id_instr_i[24:20] : '0;
    assign fetch_stop_o = id_valid_i && cls == CLS_HALT;

    assign op_a = (fwd_a_sel_i == FWD_MEM) ? mem_result_i :
                  (fwd_a_sel_i == FWD_WB)  ? wb_data_i : rs1_data_i;
    assign op_b = (fwd_b_sel_i == FWD_MEM) ? mem_result_i :
                  (fwd_b_sel_i == FWD_WB)  ? wb_data_i : rs2_data_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid_o <= 1'b0;
            ex_class_o <= CLS_NONE;
            ex_rd_o    <= '0;
        end else if (!freeze_i) begin
            if (flush_i || stall_i || !id_valid_i) begin
                ex_valid_o <= 1'b0;          // bubble
                ex_class_o <= CLS_NONE;
                ex_rd_o    <= '0;
            end else begin
                ex_valid_o <= 1'b1;
                ex_class_o <= cls;
                ex_rd_o    <= writes_rd ? id_instr_i[11:7] : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze_i) begin
            ex_alu_op_o     <= alu_op;
            ex_src1_o       <= op_a;
            ex_src2_o       <= use_imm ? imm : op_b;
            ex_store_data_o <= op_b;
            ex_pc_o         <= id_pc_i;
            ex_imm_o        <= imm;
            ex_funct3_o     <= funct3;
        end
    end

endmodule

// File: verilog/reg_file.sv
// 32 x 32 integer register file, two combinational reads with write-through
`timescale 1ns/1ps
module reg_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);
    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 reads zero, a same-cycle write is seen by decode
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                        (we_i && waddr_i == rs1_addr_i) ? wdata_i : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                        (we_i && waddr_i == rs2_addr_i) ? wdata_i : regs[rs2_addr_i];

endmodule

// File: verilog/ex_stage.sv
// execute stage: alu, branch resolution and target, and the EX/MEM register
`timescale 1ns/1ps
module ex_stage import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  ex_valid_i,
    input  instr_class_e          ex_class_i,
    input  alu_op_e               ex_alu_op_i,
    input  logic [XLEN-1:0]       ex_src1_i,
    input  logic [XLEN-1:0]       ex_src2_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_i,
    input  logic [XLEN-1:0]       ex_store_data_i,
    input  logic [XLEN-1:0]       ex_pc_i,
    input  logic [XLEN-1:0]       ex_imm_i,
    input  logic [2:0]            ex_funct3_i,
    input  logic                  freeze_i,
    output logic                  branch_taken_o,
    output logic [XLEN-1:0]       branch_target_o,
    output logic [XLEN-1:0]       fwd_data_o,
    output logic                  mem_valid_o,
    output instr_class_e          mem_class_o,
    output logic [XLEN-1:0]       mem_result_o,
    output logic [REG_ADDR_W-1:0] mem_rd_o,
    output logic [XLEN-1:0]       mem_store_data_o,
    output logic [XLEN-1:0]       mem_pc_o
);
    logic [XLEN-1:0] alu_res;
    logic            cond;

    always_comb begin
        case (ex_alu_op_i)
            ALU_SUB:    alu_res = ex_src1_i - ex_src2_i;
            ALU_AND:    alu_res = ex_src1_i & ex_src2_i;
            ALU_OR:     alu_res = ex_src1_i | ex_src2_i;
            ALU_XOR:    alu_res = ex_src1_i ^ ex_src2_i;
            ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(ex_src1_i) < $signed(ex_src2_i)};
            ALU_PASS_B: alu_res = ex_src2_i;
            default:    alu_res = ex_src1_i + ex_src2_i;   // add, load/store address
        endcase
    end

    assign cond            = ex_funct3_i[0] ? (ex_src1_i != ex_src2_i)   // bne
                                            : (ex_src1_i == ex_src2_i);  // beq
    assign branch_taken_o  = ex_valid_i && ((ex_class_i == CLS_BRANCH && cond) ||
                                            ex_class_i == CLS_JAL);
    assign branch_target_o = ex_pc_i + ex_imm_i;
    assign fwd_data_o      = (ex_class_i == CLS_JAL) ? ex_pc_i + 32'd4 : alu_res;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_valid_o <= 1'b0;
            mem_class_o <= CLS_NONE;
            mem_rd_o    <= '0;
        end else if (!freeze_i) begin
            mem_valid_o <= ex_valid_i;
            mem_class_o <= ex_class_i;
            mem_rd_o    <= ex_rd_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze_i) begin
            mem_result_o     <= fwd_data_o;
            mem_store_data_o <= ex_store_data_i;
            mem_pc_o         <= ex_pc_i;
        end
    end

endmodule

// File: verilog/mem_stage.sv
// memory stage: data memory, MEM/WB register driving the retire stream, halt flag
`timescale 1ns/1ps
module mem_stage import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  mem_valid_i,
    input  instr_class_e          mem_class_i,
    input  logic [XLEN-1:0]       mem_result_i,
    input  logic [REG_ADDR_W-1:0] mem_rd_i,
    input  logic [XLEN-1:0]       mem_store_data_i,
    input  logic [XLEN-1:0]       mem_pc_i,
    input  logic                  retire_ready_i,
    output logic                  retire_valid_o,
    output logic [XLEN-1:0]       retire_pc_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic [XLEN-1:0]       retire_data_o,
    output logic                  halt_o,
    output logic                  freeze_o,
    output logic                  wb_we_o,
    output logic [XLEN-1:0]       fwd_data_o
);
    logic [XLEN-1:0]    dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] dmem_idx;
    logic               wb_halt_q;

    assign dmem_idx   = mem_result_i[DMEM_AW+1:2];
    assign freeze_o   = retire_valid_o && !retire_ready_i;   // record held, pipe stops
    assign wb_we_o    = retire_valid_o && retire_ready_i;    // transfer edge
    // data is zero whenever no register is written
    assign fwd_data_o = (mem_rd_i == '0) ? '0 :
                        (mem_class_i == CLS_LOAD) ? dmem[dmem_idx] : mem_result_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (!freeze_o && mem_valid_i && mem_class_i == CLS_STORE) begin
            dmem[dmem_idx] <= mem_store_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            retire_valid_o <= 1'b0;
        end else if (!freeze_o) begin
            retire_valid_o <= mem_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze_o) begin
            retire_pc_o   <= mem_pc_i;
            retire_rd_o   <= mem_rd_i;
            retire_data_o <= fwd_data_o;
            wb_halt_q     <= mem_class_i == CLS_HALT;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            halt_o <= 1'b0;
        end else if (wb_we_o && wb_halt_q) begin
            halt_o <= 1'b1;      // sticky until reset
        end
    end

endmodule

// File: verilog/hazard_unit.sv
// hazard control: decode operand forwarding selects, load-use stall and branch flush
`timescale 1ns/1ps
module hazard_unit import rv_pkg::*; (
    input  logic [REG_ADDR_W-1:0] id_rs1_i,
    input  logic [REG_ADDR_W-1:0] id_rs2_i,
    input  logic [REG_ADDR_W-1:0] ex_rd_i,
    input  instr_class_e          ex_class_i,
    input  logic [REG_ADDR_W-1:0] mem_rd_i,
    input  logic                  mem_valid_i,
    input  logic                  branch_taken_i,
    output fwd_sel_e              fwd_a_sel_o,
    output fwd_sel_e              fwd_b_sel_o,
    output logic                  stall_o,
    output logic                  flush_o
);
    // youngest producer wins, x0 never forwards
    function automatic fwd_sel_e pick_src(input logic [REG_ADDR_W-1:0] rs);
        fwd_sel_e sel;
        sel = FWD_REG;
        if (rs != '0 && ex_class_i != CLS_NONE && ex_rd_i == rs) begin
            sel = FWD_MEM;
        end else if (rs != '0 && mem_valid_i && mem_rd_i == rs) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a_sel_o = pick_src(id_rs1_i);
        fwd_b_sel_o = pick_src(id_rs2_i);
    end

    // load data only exists one stage later
    assign stall_o = ex_class_i == CLS_LOAD && ex_rd_i != '0 &&
                     (ex_rd_i == id_rs1_i || ex_rd_i == id_rs2_i);
    assign flush_o = branch_taken_i;

endmodule

// File: verilog/rv_pipe_top.sv
// five-stage rv32i pipeline top, loaded through the imem port in reset and observed on retire
`timescale 1ns/1ps
module rv_pipe_top import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  imem_we_i,
    input  logic [IMEM_AW-1:0]    imem_addr_i,     // word index
    input  logic [XLEN-1:0]       imem_wdata_i,
    output logic                  retire_valid_o,
    input  logic                  retire_ready_i,
    output logic [XLEN-1:0]       retire_pc_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic [XLEN-1:0]       retire_data_o,
    output logic                  halt_o
);
    logic                  id_valid;
    logic [XLEN-1:0]       id_pc;
    logic [31:0]           id_instr;
    logic                  fetch_stop;
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [XLEN-1:0]       rs1_data, rs2_data;

    logic                  ex_valid;
    instr_class_e          ex_class;
    alu_op_e               ex_alu_op;
    logic [XLEN-1:0]       ex_src1, ex_src2, ex_store_data, ex_pc, ex_imm;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [2:0]            ex_funct3;
    logic                  branch_taken;
    logic [XLEN-1:0]       branch_target;
    logic [XLEN-1:0]       ex_fwd_data;        // result entering EX/MEM

    logic                  mem_valid;
    instr_class_e          mem_class;
    logic [XLEN-1:0]       mem_result, mem_store_data, mem_pc;
    logic [REG_ADDR_W-1:0] mem_rd;
    logic [XLEN-1:0]       mem_fwd_data;       // value entering MEM/WB

    fwd_sel_e              fwd_a_sel, fwd_b_sel;
    logic                  stall_id, flush, freeze, wb_we;

    if_stage u_if_stage (
        .clk(clk), .rst_i(rst_i),
        .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i),
        .stall_i(stall_id), .freeze_i(freeze), .flush_i(flush),
        .flush_target_i(branch_target), .fetch_stop_i(fetch_stop),
        .id_valid_o(id_valid), .id_pc_o(id_pc), .id_instr_o(id_instr)
    );

    id_stage u_id_stage (
        .clk(clk), .rst_i(rst_i),
        .id_valid_i(id_valid), .id_pc_i(id_pc), .id_instr_i(id_instr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .fwd_a_sel_i(fwd_a_sel), .fwd_b_sel_i(fwd_b_sel),
        .mem_result_i(ex_fwd_data), .wb_data_i(mem_fwd_data),
        .stall_i(stall_id), .freeze_i(freeze), .flush_i(flush),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .fetch_stop_o(fetch_stop),
        .ex_valid_o(ex_valid), .ex_class_o(ex_class), .ex_alu_op_o(ex_alu_op),
        .ex_src1_o(ex_src1), .ex_src2_o(ex_src2), .ex_rd_o(ex_rd),
        .ex_store_data_o(ex_store_data), .ex_pc_o(ex_pc), .ex_imm_o(ex_imm),
        .ex_funct3_o(ex_funct3)
    );

    reg_file u_reg_file (
        .clk(clk),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .we_i(wb_we), .waddr_i(retire_rd_o), .wdata_i(retire_data_o),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
    );

    ex_stage u_ex_stage (
        .clk(clk), .rst_i(rst_i),
        .ex_valid_i(ex_valid), .ex_class_i(ex_class), .ex_alu_op_i(ex_alu_op),
        .ex_src1_i(ex_src1), .ex_src2_i(ex_src2), .ex_rd_i(ex_rd),
        .ex_store_data_i(ex_store_data), .ex_pc_i(ex_pc), .ex_imm_i(ex_imm),
        .ex_funct3_i(ex_funct3), .freeze_i(freeze),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .fwd_data_o(ex_fwd_data),
        .mem_valid_o(mem_valid), .mem_class_o(mem_class), .mem_result_o(mem_result),
        .mem_rd_o(mem_rd), .mem_store_data_o(mem_store_data), .mem_pc_o(mem_pc)
    );

    mem_stage u_mem_stage (
        .clk(clk), .rst_i(rst_i),
        .mem_valid_i(mem_valid), .mem_class_i(mem_class), .mem_result_i(mem_result),
        .mem_rd_i(mem_rd), .mem_store_data_i(mem_store_data), .mem_pc_i(mem_pc),
        .retire_ready_i(retire_ready_i),
        .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
        .retire_rd_o(retire_rd_o), .retire_data_o(retire_data_o),
        .halt_o(halt_o), .freeze_o(freeze), .wb_we_o(wb_we), .fwd_data_o(mem_fwd_data)
    );

    hazard_unit u_hazard_unit (
        .id_rs1_i(rs1_addr), .id_rs2_i(rs2_addr),
        .ex_rd_i(ex_rd), .ex_class_i(ex_class),
        .mem_rd_i(mem_rd), .mem_valid_i(mem_valid),
        .branch_taken_i(branch_taken),
        .fwd_a_sel_o(fwd_a_sel), .fwd_b_sel_o(fwd_b_sel),
        .stall_o(stall_id), .flush_o(flush)
    );

endmodule

// File: bench/rv_pipe_chk.sv
// retire stream and reset assertions, bound into rv_pipe_top from the testbench
`timescale 1ns/1ps
module rv_pipe_chk (
    input logic        clk,
    input logic        rst_i,
    input logic        retire_valid_i,
    input logic        retire_ready_i,
    input logic [31:0] retire_pc_i,
    input logic [4:0]  retire_rd_i,
    input logic [31:0] retire_data_i,
    input logic        halt_i
);
    // outputs must be quiet once a reset edge has been seen
    a_reset_quiet: assert property (@(posedge clk) $past(rst_i) |-> !retire_valid_i && !halt_i)
        else $error("retire_valid_o or halt_o high during reset");

    a_hold_record: assert property (@(posedge clk) disable iff (rst_i)
        retire_valid_i && !retire_ready_i |=> retire_valid_i && $stable(retire_pc_i) &&
        $stable(retire_rd_i) && $stable(retire_data_i))
        else $error("retire record changed while ready was low");

    a_known_record: assert property (@(posedge clk) disable iff (rst_i)
        retire_valid_i |-> !$isunknown({retire_pc_i, retire_rd_i, retire_data_i}))
        else $error("unknown bits in a valid retire record");

    a_halt_sticky: assert property (@(posedge clk) disable iff (rst_i) halt_i |=> halt_i)
        else $error("halt_o dropped before reset");

    a_quiet_after_halt: assert property (@(posedge clk) disable iff (rst_i)
        halt_i |-> !retire_valid_i)
        else $error("record retired after halt");

endmodule

// File: bench/rv_pipe_tb.sv
// testbench of rv_pipe_top: random rv32i program, sequential reference model, retire checker
`timescale 1ns/1ps
module rv_pipe_tb;

    localparam int PROG_LEN = 40;

    typedef enum int {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_ADDI, K_ANDI,
        K_ORI, K_XORI, K_LUI, K_LW, K_SW, K_BEQ, K_BNE, K_JAL, K_EBREAK
    } kind_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
    } rec_t;

    logic        clk = 1'b0;
    logic        rst_i;
    logic        imem_we_i;
    logic [5:0]  imem_addr_i;
    logic [31:0] imem_wdata_i;
    logic        retire_valid_o;
    logic        retire_ready_i;
    logic [31:0] retire_pc_o;
    logic [4:0]  retire_rd_o;
    logic [31:0] retire_data_o;
    logic        halt_o;

    kind_e       prog_kind [PROG_LEN];
    logic [4:0]  prog_rd [PROG_LEN];
    logic [4:0]  prog_rs1 [PROG_LEN];
    logic [4:0]  prog_rs2 [PROG_LEN];
    logic [31:0] prog_imm [PROG_LEN];     // immediate as its value
    logic [31:0] model_x [32];
    logic [31:0] model_mem [16];
    rec_t        exp_q [$];
    integer      seed;
    logic [31:0] rnd;
    int          cycles, retired, model_count;

    rv_pipe_top DUT (
        .clk(clk), .rst_i(rst_i),
        .imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_wdata_i(imem_wdata_i),
        .retire_valid_o(retire_valid_o), .retire_ready_i(retire_ready_i),
        .retire_pc_o(retire_pc_o), .retire_rd_o(retire_rd_o),
        .retire_data_o(retire_data_o), .halt_o(halt_o)
    );

    bind rv_pipe_top rv_pipe_chk u_chk (
        .clk(clk), .rst_i(rst_i),
        .retire_valid_i(retire_valid_o), .retire_ready_i(retire_ready_i),
        .retire_pc_i(retire_pc_o), .retire_rd_i(retire_rd_o),
        .retire_data_i(retire_data_o), .halt_i(halt_o)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic gen_program();
        int span;
        for (int i = 0; i < PROG_LEN; i++) begin
            rnd         = $random(seed);
            prog_rd[i]  = {2'b0, rnd[14:12]};   // x0..x7 only
            prog_rs1[i] = {2'b0, rnd[17:15]};
            prog_rs2[i] = {2'b0, rnd[20:18]};
            prog_imm[i] = {{20{rnd[11]}}, rnd[11:0]};
            if (i < 7) begin
                prog_kind[i] = K_ADDI;           // give x1..x7 a known value
                prog_rd[i]   = 5'(i + 1);
                prog_rs1[i]  = 5'd0;
            end else if (i == PROG_LEN - 1) begin
                prog_kind[i] = K_EBREAK;
            end else begin
                prog_kind[i] = kind_e'(rnd[27:24]);
            end
            span = (PROG_LEN - 1 - i < 6) ? PROG_LEN - 1 - i : 6;
            case (prog_kind[i])
                K_LUI: prog_imm[i] = {rnd[31:12], 12'b0};
                K_LW, K_SW: begin
                    prog_rs1[i] = 5'd0;
                    prog_imm[i] = {26'b0, rnd[31:28], 2'b0};
                    if (prog_kind[i] == K_LW && prog_kind[i-1] == K_SW && rnd[21]) begin
                        prog_imm[i] = prog_imm[i-1];   // reload what was just stored
                    end
                end
                K_BEQ, K_BNE, K_JAL: begin
                    if (span < 2) begin
                        prog_kind[i] = K_XORI;       // no room to jump forward
                    end else begin
                        prog_imm[i] = (2 + rnd[31:28] % (span - 1)) * 4;
                        if (rnd[22]) prog_rs2[i] = prog_rs1[i];
                    end
                end
                default: ;
            endcase
        end
    endtask

    function automatic logic [31:0] encode_word(input int i);
        logic [31:0] m;
        logic [4:0]  rd, rs1, rs2;
        m   = prog_imm[i];
        rd  = prog_rd[i];
        rs1 = prog_rs1[i];
        rs2 = prog_rs2[i];
        case (prog_kind[i])
            K_ADD:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_AND:  return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_OR:   return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_XOR:  return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_SLT:  return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            K_ADDI: return {m[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_ANDI: return {m[11:0], rs1, 3'b111, rd, 7'b0010011};
            K_ORI:  return {m[11:0], rs1, 3'b110, rd, 7'b0010011};
            K_XORI: return {m[11:0], rs1, 3'b100, rd, 7'b0010011};
            K_LUI:  return {m[31:12], rd, 7'b0110111};
            K_LW:   return {m[11:0], 5'd0, 3'b010, rd, 7'b0000011};
            K_SW:   return {m[11:5], rs2, 5'd0, 3'b010, m[4:0], 7'b0100011};
            K_BEQ:  return {m[12], m[10:5], rs2, rs1, 3'b000, m[4:1], m[11], 7'b1100011};
            K_BNE:  return {m[12], m[10:5], rs2, rs1, 3'b001, m[4:1], m[11], 7'b1100011};
            K_JAL:  return {m[20], m[10:1], m[11], m[19:12], rd, 7'b1101111};
            default: return 32'h0010_0073;      // ebreak
        endcase
    endfunction

    // executes the program in order and queues one record per instruction
    task automatic run_model();
        logic [31:0] a, b, m, res;
        logic [4:0]  rd;
        rec_t        rec;
        int          idx;
        bit          done;
        idx  = 0;
        done = 1'b0;
        for (int r = 0; r < 32; r++) model_x[r] = '0;
        for (int w = 0; w < 16; w++) model_mem[w] = '0;
        while (!done && idx < PROG_LEN) begin
            a      = model_x[prog_rs1[idx]];
            b      = model_x[prog_rs2[idx]];
            m      = prog_imm[idx];
            rd     = prog_rd[idx];
            res    = '0;
            rec.pc = idx * 4;
            case (prog_kind[idx])
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_SLT:  res = {31'b0, $signed(a) < $signed(b)};
                K_ADDI: res = a + m;
                K_ANDI: res = a & m;
                K_ORI:  res = a | m;
                K_XORI: res = a ^ m;
                K_LUI:  res = m;
                K_LW:   res = model_mem[m[5:2]];
                K_SW: begin
                    model_mem[m[5:2]] = b;
                    rd = 5'd0;
                end
                K_BEQ, K_BNE: rd = 5'd0;
                K_JAL:  res = rec.pc + 32'd4;
                default: begin
                    rd   = 5'd0;
                    done = 1'b1;
                end
            endcase
            rec.rd   = rd;
            rec.data = (rd != 0) ? res : '0;
            if (rd != 0) model_x[rd] = res;
            exp_q.push_back(rec);
            if (prog_kind[idx] == K_JAL || (prog_kind[idx] == K_BEQ && a == b) ||
                (prog_kind[idx] == K_BNE && a != b)) begin
                idx += m / 4;
            end else begin
                idx += 1;
            end
        end
    endtask

    task automatic check_record();
        rec_t exp;
        if (exp_q.size() == 0) begin
            abort_run("a record retired after the model ran out of instructions");
        end
        exp = exp_q.pop_front();
        check_value("retire_pc_o", retire_pc_o, exp.pc);
        check_value("retire_rd_o", {27'b0, retire_rd_o}, {27'b0, exp.rd});
        check_value("retire_data_o", retire_data_o, exp.data);
        retired++;
    endtask

    initial begin
        seed           = 32'h1170;
        rst_i          = 1'b1;
        imem_we_i      = 1'b0;
        imem_addr_i    = '0;
        imem_wdata_i   = '0;
        retire_ready_i = 1'b0;
        retired        = 0;
        gen_program();
        run_model();
        model_count = exp_q.size();
        for (int i = 0; i < PROG_LEN; i++) begin
            @(negedge clk);
            imem_we_i    = 1'b1;
            imem_addr_i  = i[5:0];
            imem_wdata_i = encode_word(i);
        end
        @(negedge clk);
        imem_we_i = 1'b0;
        repeat (5) @(negedge clk);           // plain reset after the load
        rst_i  = 1'b0;
        cycles = 0;
        while (!halt_o && cycles < 2000) begin
            @(negedge clk);
            cycles++;
            rnd            = $random(seed);
            retire_ready_i = rnd[3:0] < 4'd11;   // high about 70 percent
            if (retire_valid_o && retire_ready_i) check_record();
        end
        if (!halt_o) abort_run("halt_o did not rise within 2000 cycles");
        repeat (10) begin
            @(negedge clk);
            rnd            = $random(seed);
            retire_ready_i = rnd[3:0] < 4'd11;
            check_value("retire_valid_o", {31'b0, retire_valid_o}, 32'h0);
            check_value("halt_o", {31'b0, halt_o}, 32'h1);
        end
        check_value("retired record count", retired, model_count);
        // architectural state left behind in the register file
        for (int r = 1; r < 8; r++) begin
            check_value($sformatf("x%0d", r), DUT.u_reg_file.regs[r], model_x[r]);
        end
        $display("test passed");
        $finish;
    end

endmodule

// File: rv_pipe_top.f
verilog/rv_pkg.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/reg_file.sv
verilog/ex_stage.sv
verilog/mem_stage.sv
verilog/hazard_unit.sv
verilog/rv_pipe_top.sv
bench/rv_pipe_chk.sv
bench/rv_pipe_tb.sv
